// File: Makefile
VERILATOR  ?= verilator
FILELIST   ?= verilog.f
TB_TOP     ?= tb_i2c_regf
RTL_TOP    ?= tt_um_i2c_regf
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG   ?= Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TB_TOP) -f $(FILELIST)

# Pass or fail comes from the printed result, not from the exit code
run: build
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: dv/i2c_master_tasks.svh
// Bus master tasks: SDA release with timeout, START, STOP, single SCL pulse, byte write, byte read
`ifndef I2C_MASTER_TASKS_SVH
`define I2C_MASTER_TASKS_SVH

  // Master lets SDA go high, the target gets a bounded time to release it too
  task automatic release_sda();
    int waited;
    sda_drv = 1'b1;
    waited  = 0;
    while (sda_bus !== 1'b1 && waited < SDA_WAIT) begin
      tick(1);
      waited++;
    end
    assert (sda_bus === 1'b1) else
      stop_on_error("Timeout: the target kept SDA low after the master released it");
  endtask

  // Works from idle and as a repeated START from the low phase after an ACK slot
  task automatic start_bus();
    tick(4);
    release_sda();
    tick(HALF - 4);
    scl_drv = 1'b1;
    tick(HALF);
    sda_drv = 1'b0;  // SDA falls while SCL high
    tick(HALF);
    scl_drv = 1'b0;
  endtask

  task automatic stop_bus();
    tick(4);
    sda_drv = 1'b0;
    tick(HALF - 4);
    scl_drv = 1'b1;
    tick(HALF);
    release_sda();   // SDA rises while SCL high
    tick(HALF);
  endtask

  // One SCL pulse, SDA set inside the low phase and sampled mid high phase
  task automatic clock_bit(input logic sda_val, output logic sampled);
    tick(4);         // Hold after the falling edge
    sda_drv = sda_val;
    tick(HALF - 4);
    scl_drv = 1'b1;
    tick(HALF / 2);
    sampled = sda_bus;
    tick(HALF / 2);
    scl_drv = 1'b0;
  endtask

  task automatic write_byte(input logic [7:0] data, output logic acked);
    logic bus_bit;
    for (int i = 7; i >= 0; i--) begin
      clock_bit(data[i], bus_bit);  // MSB first
    end
    clock_bit(1'b1, bus_bit);       // Released for the target ACK
    acked = ~bus_bit;
  endtask

  task automatic read_byte(output logic [7:0] data, input logic more);
    logic bus_bit;
    for (int i = 7; i >= 0; i--) begin
      clock_bit(1'b1, bus_bit);
      data[i] = bus_bit;
    end
    clock_bit(~more, bus_bit);      // Low asks for another byte
  endtask

`endif

// File: dv/tb_i2c_regf.sv
// Testbench top with clock, reset, open-drain bus, register model, reference function, checks, tests
module tb_i2c_regf;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [6:0] DEV_ADDR   = 7'h2A;
  localparam logic [6:0] OTHER_ADDR = 7'h15;  // Nobody answers here
  localparam int         HALF       = 12;     // Clk cycles per SCL phase
  localparam int         SDA_WAIT   = 20;     // Cycles allowed for SDA release

  logic       clk;
  logic       rst_n;
  logic       scl_drv;   // Master side of the bus
  logic       sda_drv;
  logic       sda_bus;   // Wired-AND of master and target
  logic [7:0] uo_out;
  logic [7:0] uio_out;
  logic [7:0] uio_oe;
  logic [7:0] model_regs [16];  // Mirror of the register file
  logic [3:0] model_ptr;        // Mirror of the pointer wrapping at 16
  logic       idle_chk;         // High while uo_out must follow model register 0
  logic       rd_valid;         // Strobe to the compare process
  logic [7:0] rd_byte;
  logic [7:0] rd_exp;

  assign sda_bus = sda_drv & ~uio_oe[0];  // Target pulls by enabling its low output

  tt_um_i2c_regf #(
    .DEVICE_ADDR (DEV_ADDR),
    .ADDR_WIDTH  (4)
  ) u_tt_um_i2c_regf (
    .ui_in   ({7'h00, scl_drv}),
    .uo_out  (uo_out),
    .uio_in  ({7'h00, sda_bus}),
    .uio_out (uio_out),
    .uio_oe  (uio_oe),
    .ena     (1'b1),
    .clk     (clk),
    .rst_n   (rst_n)
  );

  always #2 clk = ~clk;  // 4 ns period

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Waits n edges plus 1 ns so all bus drives land here
  task automatic tick(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  `include "i2c_master_tasks.svh"

  // Expected read byte at pointer plus offset with wrap modulo 16
  function automatic logic [7:0] expected_byte(input logic [3:0] ptr, input int offset);
    int idx;
    idx = (int'(ptr) + offset) % 16;
    return model_regs[idx[3:0]];
  endfunction

  task automatic check_ack(input logic got, input logic exp, input string name);
    assert (got === exp) else
      stop_on_error($sformatf("MISMATCH at %0d ns: %s expected %0b, got %0b",
                              $time, name, exp, got));
  endtask

  task automatic send_addr(input logic [6:0] addr, input logic rd, input logic exp_ack);
    logic acked;
    idle_chk = 1'b0;
    start_bus();
    write_byte({addr, rd}, acked);
    check_ack(acked, exp_ack, "address ACK");
  endtask

  // Pointer byte then len random data bytes. Without STOP a repeated START may follow
  task automatic write_regs(input logic [7:0] ptr, input int len, input logic end_stop);
    logic       acked;
    logic [7:0] data;
    send_addr(DEV_ADDR, 1'b0, 1'b1);
    write_byte(ptr, acked);
    check_ack(acked, 1'b1, "pointer ACK");
    model_ptr = ptr[3:0];  // Upper pointer bits dropped
    for (int i = 0; i < len; i++) begin
      data = 8'($urandom);
      write_byte(data, acked);
      check_ack(acked, 1'b1, "data ACK");
      model_regs[model_ptr] = data;
      model_ptr = model_ptr + 4'd1;
    end
    if (end_stop) begin
      stop_bus();
      idle_chk = 1'b1;
    end
  endtask

  task automatic read_regs(input int len);
    logic [7:0] data;
    send_addr(DEV_ADDR, 1'b1, 1'b1);
    for (int i = 0; i < len; i++) begin
      read_byte(data, i != len - 1);  // NACK ends the read
      rd_exp   = expected_byte(model_ptr, i);
      rd_byte  = data;
      rd_valid = 1'b1;
      tick(1);
      rd_valid = 1'b0;
    end
    model_ptr = model_ptr + 4'(len);  // NACKed byte counts too
    stop_bus();
    idle_chk = 1'b1;
  endtask

  // Foreign address with every byte unanswered
  task automatic foreign_txn(input logic rd);
    logic acked;
    send_addr(OTHER_ADDR, rd, 1'b0);
    if (!rd) begin
      write_byte(8'h00, acked);
      check_ack(acked, 1'b0, "data ACK");
      write_byte(8'hA5, acked);
      check_ack(acked, 1'b0, "data ACK");
    end
    stop_bus();
    idle_chk = 1'b1;
  endtask

  // Compare process
  always @(posedge clk) begin
    if (rd_valid) begin
      assert (rd_byte === rd_exp) else
        stop_on_error($sformatf("MISMATCH at %0d ns: read byte expected %02h, got %02h",
                                $time, rd_exp, rd_byte));
    end
    if (idle_chk) begin
      assert (uo_out === model_regs[0]) else
        stop_on_error($sformatf("MISMATCH at %0d ns: uo_out expected %02h, got %02h",
                                $time, model_regs[0], uo_out));
    end
    // Open drain means the output level stays low and only bit 0 may be enabled
    assert (uio_out === 8'h00) else
      stop_on_error($sformatf("MISMATCH at %0d ns: uio_out expected 00, got %02h",
                              $time, uio_out));
    assert (uio_oe[7:1] === 7'h00) else
      stop_on_error($sformatf("MISMATCH at %0d ns: uio_oe[7:1] expected 00, got %02h",
                              $time, uio_oe[7:1]));
  end

  initial begin
    int kind;
    int len;
    void'($urandom(32'h058ff4d6));  // Fixed seed
    clk       = 1'b0;
    rst_n     = 1'b0;
    scl_drv   = 1'b1;  // Idle bus
    sda_drv   = 1'b1;
    idle_chk  = 1'b0;
    rd_valid  = 1'b0;
    rd_byte   = '0;
    rd_exp    = '0;
    model_ptr = '0;
    for (int i = 0; i < 16; i++) begin
      model_regs[i] = '0;
    end
    tick(2);
    rst_n    = 1'b1;
    idle_chk = 1'b1;
    tick(HALF);
    read_regs(16);                  // All zero after reset
    write_regs(8'h03, 5, 1'b1);
    write_regs(8'h03, 0, 1'b0);     // Repeated START read from the same pointer
    read_regs(5);
    write_regs(8'hFE, 4, 1'b1);     // Pointer 14 so writes wrap to 0
    write_regs(8'h1E, 0, 1'b0);
    read_regs(4);                   // Reads wrap too
    read_regs(14);
    foreign_txn(1'b0);
    foreign_txn(1'b1);
    read_regs(16);                  // Registers and pointer untouched
    for (int t = 0; t < 40; t++) begin
      kind = $urandom_range(2, 0);
      len  = $urandom_range(6, 1);
      if (kind == 0) begin
        write_regs(8'($urandom), len, 1'b1);
      end else if (kind == 1) begin
        write_regs(8'($urandom), 0, 1'b0);
        read_regs(len);
      end else begin
        read_regs(len);             // From the current pointer
      end
    end
    read_regs(16);
    $display("Done: no errors");
    $finish;
  end

endmodule

// File: hdl/i2c_bus_decode.sv
// I2C bus decoder: SCL/SDA synchronizer, START/STOP detect, byte shifters and ACK slot handling
module i2c_bus_decode (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     scl,
  input  logic                     sda,
  input  i2c_regf_pkg::bus_resp_t  resp,
  output i2c_regf_pkg::bus_evt_t   evt,
  output logic                     sda_pull
);
  import i2c_regf_pkg::*;

  logic [1:0] scl_sync;  // Two-stage synchronizers
  logic [1:0] sda_sync;
  logic       scl_prev;  // Synchronized value one cycle earlier
  logic       sda_prev;
  logic       scl_s;
  logic       sda_s;

  logic       scl_rise;
  logic       scl_fall;
  logic       start_det;
  logic       stop_det;

  logic [3:0] bit_cnt;   // Rising edges seen in the current byte frame, 8 = ACK slot pending
  logic       ack_slot;  // Inside the ninth clock
  logic       tx_mode;   // Current byte is shifted out by the target

  logic       ack_enter; // Falling edge after the eighth bit
  logic       ack_exit;  // Falling edge after the ACK bit
  logic       tx_shift;  // Falling edge inside a read byte
  logic       rx_shift;  // Rising edge inside a byte

  logic       start_q;
  logic       stop_q;
  logic       done_q;
  logic       mack_q;
  logic       mnack_q;
  byte_t      rx_sh;
  byte_t      tx_sh;

  // Idle bus is high, so sync stages reset to 1
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      scl_sync <= 2'b11;
      sda_sync <= 2'b11;
      scl_prev <= 1'b1;
      sda_prev <= 1'b1;
    end else begin
      scl_sync <= {scl_sync[0], scl};
      sda_sync <= {sda_sync[0], sda};
      scl_prev <= scl_sync[1];
      sda_prev <= sda_sync[1];
    end
  end

  assign scl_s = scl_sync[1];
  assign sda_s = sda_sync[1];

  assign scl_rise  = scl_s & ~scl_prev;
  assign scl_fall  = ~scl_s & scl_prev;
  assign start_det = scl_s & scl_prev & sda_prev & ~sda_s;  // SDA falls, SCL high
  assign stop_det  = scl_s & scl_prev & ~sda_prev & sda_s;  // SDA rises, SCL high

  assign rx_shift  = scl_rise & (bit_cnt < 4'd8);
  assign ack_enter = scl_fall & (bit_cnt == 4'd8);
  assign ack_exit  = scl_fall & (bit_cnt != 4'd8) & ack_slot;
  // First fall after START has bit_cnt 0 and is skipped
  assign tx_shift  = scl_fall & (bit_cnt != 4'd8) & ~ack_slot & tx_mode & (bit_cnt != 4'd0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt  <= 4'd0;
      ack_slot <= 1'b0;
      tx_mode  <= 1'b0;
      sda_pull <= 1'b0;
      start_q  <= 1'b0;
      stop_q   <= 1'b0;
      done_q   <= 1'b0;
      mack_q   <= 1'b0;
      mnack_q  <= 1'b0;
    end else begin
      start_q <= start_det;
      stop_q  <= stop_det;
      done_q  <= 1'b0;
      mack_q  <= 1'b0;
      mnack_q <= 1'b0;
      if (start_det || stop_det) begin  // Frame restarts, release the bus
        bit_cnt  <= 4'd0;
        ack_slot <= 1'b0;
        tx_mode  <= 1'b0;
        sda_pull <= 1'b0;
      end else if (rx_shift) begin
        bit_cnt <= bit_cnt + 4'd1;
        done_q  <= (bit_cnt == 4'd7) & ~tx_mode;  // Eighth bit of a written byte
      end else if (scl_rise) begin  // ACK bit rising edge
        bit_cnt <= 4'd0;
        mack_q  <= tx_mode & ~sda_s;
        mnack_q <= tx_mode & sda_s;
      end else if (ack_enter) begin
        ack_slot <= 1'b1;
        sda_pull <= ~tx_mode & resp.ack_en;  // Release in read mode so the master can answer
      end else if (ack_exit) begin
        ack_slot <= 1'b0;
        tx_mode  <= resp.tx_en;
        sda_pull <= resp.tx_en & ~resp.tx_byte[7];  // MSB of a read byte
      end else if (tx_shift) begin
        sda_pull <= ~tx_sh[7];  // Only zero bits pull the line
      end else if (scl_fall) begin
        sda_pull <= 1'b0;
      end
    end
  end

  // Byte shift registers, payload only
  always_ff @(posedge clk) begin
    if (rx_shift) rx_sh <= {rx_sh[6:0], sda_s};
    if (ack_exit) begin
      tx_sh <= {resp.tx_byte[6:0], 1'b0};  // Bit 7 already on the line
    end else if (tx_shift) begin
      tx_sh <= {tx_sh[6:0], 1'b0};
    end
  end

  always_comb begin
    evt.start       = start_q;
    evt.stop        = stop_q;
    evt.byte_done   = done_q;
    evt.master_ack  = mack_q;
    evt.master_nack = mnack_q;
    evt.rx_byte     = rx_sh;  // Stable from byte_done to the next rising edge
  end

endmodule

// File: hdl/i2c_regf_pkg.sv
// Shared types: byte and address vectors, bus event/response structs, register request, FSM states
package i2c_regf_pkg;

  // One I2C data byte, register value or pointer
  typedef logic [7:0] byte_t;

  // 7-bit I2C device address
  typedef logic [6:0] dev_addr_t;

  // Decoder to controller, all flags are single-cycle pulses
  typedef struct packed {
    logic  start;        // START or repeated START
    logic  stop;         // STOP
    logic  byte_done;    // Received byte complete, rx_byte valid
    logic  master_ack;   // Master wants another read byte
    logic  master_nack;  // Master ends the read
    byte_t rx_byte;      // Last byte shifted in
  } bus_evt_t;

  // Controller to decoder, sampled at SCL falling edges
  typedef struct packed {
    logic  ack_en;   // Pull SDA in the next acknowledge slot
    logic  tx_en;    // Next byte phase is a read byte
    byte_t tx_byte;  // Byte to shift out, MSB first
  } bus_resp_t;

  // Controller to register file, four-phase handshake
  typedef struct packed {
    logic  req;    // Request, held until ack seen
    logic  rw;     // 1 = write
    byte_t addr;   // Register index, low ADDR_WIDTH bits used
    byte_t wdata;  // Write data
  } regf_req_t;

  // Transaction controller states
  typedef enum logic [2:0] {
    IDLE,    // Bus free or not addressed
    ADDR,    // Expecting device address byte
    PTR,     // Expecting register pointer byte
    WDATA,   // Write data bytes
    RDATA,   // Read data bytes
    IGNORE   // Other device addressed
  } xfer_state_t;

endpackage

// File: hdl/i2c_xfer_ctrl.sv
// I2C transaction controller: address match, register pointer and four-phase register requests
module i2c_xfer_ctrl #(
  parameter i2c_regf_pkg::dev_addr_t DEVICE_ADDR = 7'h2A,
  parameter int                      ADDR_WIDTH  = 4
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  i2c_regf_pkg::bus_evt_t   evt,
  output i2c_regf_pkg::bus_resp_t  resp,
  output i2c_regf_pkg::regf_req_t  regf,
  input  logic                     ack,
  input  i2c_regf_pkg::byte_t      rdata
);
  import i2c_regf_pkg::*;

  xfer_state_t           state;
  logic [ADDR_WIDTH-1:0] ptr;         // Register pointer, wraps modulo 2^ADDR_WIDTH
  logic                  fetch_pend;  // Read fetch waiting for a free handshake
  logic                  addr_hit;    // Received address byte selects this target
  logic                  hs_idle;     // Both req and ack low, new request allowed

  assign addr_hit = (evt.rx_byte[7:1] == DEVICE_ADDR);
  assign hs_idle  = ~regf.req & ~ack;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= IDLE;
      ptr        <= '0;
      fetch_pend <= 1'b0;
      resp       <= '0;
      regf       <= '0;
    end else begin
      // Handshake side, completes a request or launches a pending fetch
      if (regf.req && ack) begin
        regf.req <= 1'b0;  // Phase 3, ack drops next cycle
        if (regf.rw) begin
          ptr <= ptr + 1'b1;  // Write landed
        end else begin
          resp.tx_byte <= rdata;  // Read data valid while ack high
        end
      end else if (fetch_pend && hs_idle) begin
        regf.req   <= 1'b1;
        regf.rw    <= 1'b0;
        regf.addr  <= byte_t'(ptr);
        fetch_pend <= 1'b0;
      end

      // Bus side
      if (evt.start) begin
        state       <= ADDR;
        resp.ack_en <= 1'b0;  // No ACK unless the address matches
        resp.tx_en  <= 1'b0;
        fetch_pend  <= 1'b0;
      end else if (evt.stop) begin
        state       <= IDLE;
        resp.ack_en <= 1'b0;
        resp.tx_en  <= 1'b0;
        fetch_pend  <= 1'b0;
      end else begin
        case (state)
          ADDR: begin
            if (evt.byte_done) begin
              if (!addr_hit) begin
                state <= IGNORE;  // Stay silent until START or STOP
              end else if (evt.rx_byte[0]) begin
                state       <= RDATA;
                resp.ack_en <= 1'b1;
                resp.tx_en  <= 1'b1;
                fetch_pend  <= 1'b1;  // First read byte fetched before the ACK slot ends
              end else begin
                state       <= PTR;
                resp.ack_en <= 1'b1;
              end
            end
          end
          PTR: begin
            if (evt.byte_done) begin
              ptr   <= evt.rx_byte[ADDR_WIDTH-1:0];  // Upper pointer bits dropped
              state <= WDATA;
            end
          end
          WDATA: begin
            if (evt.byte_done) begin  // Phase 1 of a write
              regf.req   <= 1'b1;
              regf.rw    <= 1'b1;
              regf.addr  <= byte_t'(ptr);
              regf.wdata <= evt.rx_byte;
            end
          end
          RDATA: begin
            if (evt.master_ack) begin
              ptr        <= ptr + 1'b1;
              fetch_pend <= 1'b1;  // Next byte from the new pointer
            end else if (evt.master_nack) begin
              ptr         <= ptr + 1'b1;  // Last byte still counts as transferred
              state       <= IDLE;
              resp.ack_en <= 1'b0;
              resp.tx_en  <= 1'b0;
            end
          end
          default: begin
            state <= state;  // IDLE and IGNORE wait for START or STOP
          end
        endcase
      end
    end
  end

endmodule

// File: hdl/reg_file.sv
// Byte register file with four-phase request/acknowledge port and register 0 export
module reg_file #(
  parameter int ADDR_WIDTH = 4
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  i2c_regf_pkg::regf_req_t  regf,
  output logic                     ack,
  output i2c_regf_pkg::byte_t      rdata,
  output i2c_regf_pkg::byte_t      reg0
);
  import i2c_regf_pkg::*;

  localparam int NUM_REGS = 2 ** ADDR_WIDTH;

  byte_t                 regs [NUM_REGS];
  logic [ADDR_WIDTH-1:0] idx;     // Register index from the request
  logic                  accept;  // Phase 1 seen, ack about to rise

  assign idx    = regf.addr[ADDR_WIDTH-1:0];
  assign accept = regf.req & ~ack;

  // Registers and ack
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack <= 1'b0;
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      ack <= regf.req;  // Follows req with one cycle of delay
      if (accept && regf.rw) begin
        regs[idx] <= regf.wdata;  // Write on the edge where ack rises
      end
    end
  end

  // Read data captured once, held while ack is high
  always_ff @(posedge clk) begin
    if (accept) begin
      rdata <= regs[idx];
    end
  end

  assign reg0 = regs[0];  // Shown on the output pins

endmodule

// File: hdl/tt_um_i2c_regf.sv
// TinyTapeout top level: pin map for the I2C target and register file
module tt_um_i2c_regf #(
  parameter i2c_regf_pkg::dev_addr_t DEVICE_ADDR = 7'h2A,
  parameter int                      ADDR_WIDTH  = 4
) (
  input  logic [7:0] ui_in,    // ui_in[0] is SCL
  output logic [7:0] uo_out,   // Register 0
  input  logic [7:0] uio_in,   // uio_in[0] is SDA
  output logic [7:0] uio_out,
  output logic [7:0] uio_oe,   // uio_oe[0] high pulls SDA low
  input  logic       ena,
  input  logic       clk,
  input  logic       rst_n
);
  import i2c_regf_pkg::*;

  bus_evt_t  evt;
  bus_resp_t resp;
  regf_req_t regf;
  logic      regf_ack;
  byte_t     regf_rdata;
  byte_t     reg0;
  logic      sda_pull;
  logic      unused_inputs;

  // Open drain, the output level is always low and the enable does the pulling
  assign uio_out       = 8'h00;
  assign uio_oe        = {7'h00, sda_pull};
  assign uo_out        = reg0;
  assign unused_inputs = &{1'b0, ena, ui_in[7:1], uio_in[7:1]};

  i2c_bus_decode u_i2c_bus_decode (
    .clk      (clk),
    .rst_n    (rst_n),
    .scl      (ui_in[0]),
    .sda      (uio_in[0]),
    .resp     (resp),
    .evt      (evt),
    .sda_pull (sda_pull)
  );

  i2c_xfer_ctrl #(
    .DEVICE_ADDR (DEVICE_ADDR),
    .ADDR_WIDTH  (ADDR_WIDTH)
  ) u_i2c_xfer_ctrl (
    .clk   (clk),
    .rst_n (rst_n),
    .evt   (evt),
    .resp  (resp),
    .regf  (regf),
    .ack   (regf_ack),
    .rdata (regf_rdata)
  );

  reg_file #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_reg_file (
    .clk   (clk),
    .rst_n (rst_n),
    .regf  (regf),
    .ack   (regf_ack),
    .rdata (regf_rdata),
    .reg0  (reg0)
  );

endmodule

// File: verilog.f
+incdir+dv
hdl/i2c_regf_pkg.sv
hdl/i2c_bus_decode.sv
hdl/i2c_xfer_ctrl.sv
hdl/reg_file.sv
hdl/tt_um_i2c_regf.sv
dv/tb_i2c_regf.sv
